//--- source/iu_ctrl_macros.svh
// Width constants for the integer unit control block, included by every source file
`ifndef IU_CTRL_MACROS_SVH
`define IU_CTRL_MACROS_SVH

// ====================
// Datapath widths
// ====================

// Result word carried on forward and writeback paths
`define IU_DATA_W 32

// Physical register tag
`define IU_PREG_W 6

// EX1 forward sources: lsu, alu, bju, mul, div
`define IU_FWD_SRC_NUM 5

`endif

//--- source/iu_ctrl_pkg.sv
// Packed struct types shared by the integer unit control RTL and its testbench
`include "iu_ctrl_macros.svh"

package iu_ctrl_pkg;

  // One result on a forward or writeback path
  typedef struct packed {
    logic                  vld;
    logic [`IU_PREG_W-1:0] preg;
    logic [`IU_DATA_W-1:0] data;
  } fwd_bus_t;

  // EX1 one-hot completion flags, lsu in the top bit
  typedef struct packed {
    logic lsu;
    logic alu;
    logic bju;
    logic mul;
    logic div;
  } cmplt_sel_t;

  // Decoder instruction word in EX1
  typedef struct packed {
    logic                  inst_vld;
    logic                  gateclk_vld;
    logic                  alu_sel;
    logic                  mul_sel;
    logic                  wb_vld;
    logic                  rd_pair;
    logic [`IU_PREG_W-1:0] dst_preg;
    logic                  inst_len;
    logic                  split;
    logic                  ipop_int_mask;
    logic                  ipush_mie_en;
    logic                  ipush_spec_fail;
    logic                  tail_int_vld;
  } ex1_inst_t;

  // EX1 completion and interrupt tags to retire
  typedef struct packed {
    logic cmplt;
    logic cmplt_dp;
    logic inst_vld;
    logic inst_len;
    logic split_inst;
    logic ipop_int_mask;
    logic ipush_mie_en;
    logic ipush_spec_fail;
    logic tail_int_vld;
  } rtu_ex1_t;

endpackage

//--- source/iu_ex1_fwd_mux.sv
// EX1 forward source select, driven by the one-hot completion vector from the units
`include "iu_ctrl_macros.svh"

module iu_ex1_fwd_mux (
  input  iu_ctrl_pkg::cmplt_sel_t cmplt_sel,
  input  logic [`IU_PREG_W-1:0]   dst_preg,
  input  logic [`IU_DATA_W-1:0]   alu_rslt,
  input  logic [`IU_DATA_W-1:0]   bju_rslt,
  input  logic [`IU_DATA_W-1:0]   div_data,
  input  logic                    alu_fwd_vld,
  input  logic                    bju_rslt_vld,
  input  logic                    div_fwd_vld,
  input  iu_ctrl_pkg::fwd_bus_t   ag_fwd,
  output iu_ctrl_pkg::fwd_bus_t   ex1_fwd
);

  import iu_ctrl_pkg::*;

  logic [`IU_FWD_SRC_NUM-1:0] sel_vec;

  // Flat view of the flags: lsu, alu, bju, mul, div
  assign sel_vec = cmplt_sel;

  always_comb
  begin
    case (sel_vec)
      5'b10000:
      begin
        // Load address path brings its own tag
        ex1_fwd.vld  = ag_fwd.vld;
        ex1_fwd.preg = ag_fwd.preg;
        ex1_fwd.data = ag_fwd.data;
      end
      5'b01000:
      begin
        ex1_fwd.vld  = alu_fwd_vld;
        ex1_fwd.preg = dst_preg;
        ex1_fwd.data = alu_rslt;
      end
      5'b00100:
      begin
        ex1_fwd.vld  = bju_rslt_vld;
        ex1_fwd.preg = dst_preg;
        ex1_fwd.data = bju_rslt;
      end
      5'b00010:
      begin
        // MUL only reserves the tag here, data comes in EX2
        ex1_fwd.vld  = 1'b0;
        ex1_fwd.preg = dst_preg;
        ex1_fwd.data = alu_rslt;
      end
      5'b00001:
      begin
        ex1_fwd.vld  = div_fwd_vld;
        ex1_fwd.preg = dst_preg;
        ex1_fwd.data = div_data;
      end
      default:
      begin
        ex1_fwd = '0;
      end
    endcase
  end

endmodule

//--- source/iu_ex1_ex2_pipe.sv
// EX1 result qualification and the EX1 to EX2 result register feeding writeback
`include "iu_ctrl_macros.svh"

module iu_ex1_ex2_pipe (
  input  logic                    iu_ex1_fwd_dp_clk,
  input  logic                    cpurst_b,
  input  iu_ctrl_pkg::ex1_inst_t  ex1_inst,
  input  iu_ctrl_pkg::fwd_bus_t   ex1_fwd,
  input  logic                    bju_rslt_vld,
  input  logic                    spec_expt_pending,
  input  logic                    spec_halt_pending,
  input  logic                    warm_up,
  input  logic                    flush,
  output iu_ctrl_pkg::fwd_bus_t   ex2_rslt,
  output logic                    ex2_rd_pair
);

  import iu_ctrl_pkg::*;

  logic                  alu_wb_vld;
  logic                  ex1_rslt_vld;
  logic                  inst_pipe_down;
  logic                  ex2_vld;
  logic [`IU_PREG_W-1:0] ex2_preg;
  logic [`IU_DATA_W-1:0] ex2_data;

  assign alu_wb_vld = ex1_inst.inst_vld & ex1_inst.alu_sel & ex1_inst.wb_vld;

  // No result moves on while retire holds a speculative exception or halt
  assign ex1_rslt_vld = (bju_rslt_vld | alu_wb_vld) &
                        ~(spec_expt_pending | spec_halt_pending);

  // ALU or MUL in EX1 needs its tag in EX2
  assign inst_pipe_down = ex1_inst.inst_vld & (ex1_inst.alu_sel | ex1_inst.mul_sel);

  always_ff @(posedge iu_ex1_fwd_dp_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_vld <= 1'b0;
    else if (flush)
      ex2_vld <= 1'b0;
    else
      ex2_vld <= ex1_rslt_vld;
  end

  always_ff @(posedge iu_ex1_fwd_dp_clk)
  begin
    if (ex1_rslt_vld | warm_up)
      ex2_data <= ex1_fwd.data;
  end

  // Tag also follows ALU and MUL instructions, the MUL result uses it in EX2
  always_ff @(posedge iu_ex1_fwd_dp_clk)
  begin
    if (ex1_rslt_vld | inst_pipe_down | warm_up)
    begin
      ex2_preg    <= ex1_fwd.preg;
      ex2_rd_pair <= ex1_inst.rd_pair;
    end
  end

  assign ex2_rslt.vld  = ex2_vld;
  assign ex2_rslt.preg = ex2_preg;
  assign ex2_rslt.data = ex2_data;

endmodule

//--- source/iu_wb_arbiter.sv
// Fixed priority arbiter for the shared EX2 writeback port wb0 and the LSU and DIV grants
`include "iu_ctrl_macros.svh"

module iu_wb_arbiter (
  input  iu_ctrl_pkg::fwd_bus_t ex2_rslt,
  input  iu_ctrl_pkg::fwd_bus_t lsu_rslt,
  input  iu_ctrl_pkg::fwd_bus_t div_rslt,
  input  logic                  mul_inst_vld,
  input  logic                  mul_rslt_vld,
  input  logic [`IU_DATA_W-1:0] mul_rslt,
  output iu_ctrl_pkg::fwd_bus_t wb0,
  output logic                  ex2_inst_vld,
  output logic                  div_grant,
  output logic                  lsu_grant,
  output logic                  div_vld,
  output logic                  ex2_idle
);

  import iu_ctrl_pkg::*;

  logic lsu_slot_free;
  logic lsu_win;

  // ====================
  // Grants
  // ====================

  // Pipe or MUL in EX2 owns the port this cycle
  assign ex2_inst_vld = ex2_rslt.vld | mul_inst_vld;

  assign lsu_slot_free = ~ex2_inst_vld;
  assign lsu_win       = lsu_rslt.vld & lsu_slot_free;
  assign lsu_grant     = lsu_win;

  // DIV goes last, behind a waiting short load
  assign div_grant = ~ex2_inst_vld & ~lsu_rslt.vld;
  assign div_vld   = div_rslt.vld & div_grant;

  // ====================
  // wb0 select
  // ====================

  always_comb
  begin
    if (ex2_rslt.vld)
    begin
      wb0 = ex2_rslt;
    end
    else if (mul_rslt_vld)
    begin
      // MUL tag was carried down the EX1 pipe
      wb0.vld  = 1'b1;
      wb0.preg = ex2_rslt.preg;
      wb0.data = mul_rslt;
    end
    else if (lsu_win)
    begin
      wb0 = lsu_rslt;
    end
    else if (div_vld)
    begin
      wb0 = div_rslt;
    end
    else
    begin
      wb0 = '0;
    end
  end

  // Nothing writing back and no multiply still in flight
  assign ex2_idle = ~wb0.vld & ~mul_inst_vld;

endmodule

//--- source/iu_retire_ctrl.sv
// Completion and interrupt tag signals for retire, plus the EX1 stall and unit idle flag
`include "iu_ctrl_macros.svh"

module iu_retire_ctrl (
  input  iu_ctrl_pkg::ex1_inst_t ex1_inst,
  input  logic                   alu_cmplt,
  input  logic                   alu_cmplt_dp,
  input  logic                   mul_cmplt,
  input  logic                   mul_cmplt_dp,
  input  logic                   div_cmplt,
  input  logic                   div_cmplt_dp,
  input  logic                   fpu_cmplt,
  input  logic                   fpu_cmplt_dp,
  input  logic                   spec_expt_pending,
  input  logic                   spec_halt_pending,
  input  logic                   div_stall,
  input  logic                   bju_stall,
  input  logic                   bju_no_op,
  input  logic                   div_itering,
  input  logic                   ex2_idle,
  output iu_ctrl_pkg::rtu_ex1_t  rtu_ex1,
  output logic                   ex1_stall,
  output logic                   no_op
);

  import iu_ctrl_pkg::*;

  logic spec_pending;

  assign spec_pending = spec_expt_pending | spec_halt_pending;

  always_comb
  begin
    rtu_ex1.cmplt      = alu_cmplt | mul_cmplt | div_cmplt | fpu_cmplt;
    rtu_ex1.cmplt_dp   = alu_cmplt_dp | mul_cmplt_dp | div_cmplt_dp | fpu_cmplt_dp;
    rtu_ex1.inst_vld   = ex1_inst.gateclk_vld;
    rtu_ex1.inst_len   = ex1_inst.inst_len;
    rtu_ex1.split_inst = ex1_inst.split;
    // Interrupt tags only count when the ALU finishes the instruction
    rtu_ex1.ipop_int_mask   = ex1_inst.ipop_int_mask & alu_cmplt_dp;
    rtu_ex1.ipush_mie_en    = ex1_inst.ipush_mie_en & alu_cmplt_dp & ~spec_pending;
    rtu_ex1.ipush_spec_fail = ex1_inst.ipush_spec_fail & alu_cmplt_dp;
    rtu_ex1.tail_int_vld    = ex1_inst.tail_int_vld & alu_cmplt_dp;
  end

  assign ex1_stall = div_stall | bju_stall;

  // Idle needs EX1 and EX2 empty, BJU quiet and the divider stopped
  assign no_op = ~ex1_inst.inst_vld & ex2_idle & bju_no_op & ~div_itering;

endmodule

//--- source/iu_ctrl_top.sv
// Integer unit control top level, connects forward select, EX2 pipe, writeback and retire
`include "iu_ctrl_macros.svh"

module iu_ctrl_top (
  input  logic                    iu_ex1_fwd_dp_clk,
  input  logic                    cpurst_b,
  input  iu_ctrl_pkg::cmplt_sel_t cmplt_sel,
  input  iu_ctrl_pkg::ex1_inst_t  ex1_inst,
  input  logic [`IU_DATA_W-1:0]   alu_rslt,
  input  logic                    alu_fwd_vld,
  input  logic [`IU_DATA_W-1:0]   bju_rslt,
  input  logic                    bju_rslt_vld,
  input  logic [`IU_DATA_W-1:0]   div_data,
  input  logic                    div_fwd_vld,
  input  iu_ctrl_pkg::fwd_bus_t   ag_fwd,
  input  logic                    spec_expt_pending,
  input  logic                    spec_halt_pending,
  input  logic                    warm_up,
  input  logic                    flush,
  input  iu_ctrl_pkg::fwd_bus_t   lsu_rslt,
  input  iu_ctrl_pkg::fwd_bus_t   div_rslt,
  input  logic                    mul_inst_vld,
  input  logic                    mul_rslt_vld,
  input  logic [`IU_DATA_W-1:0]   mul_rslt,
  input  logic                    alu_cmplt,
  input  logic                    mul_cmplt,
  input  logic                    div_cmplt,
  input  logic                    fpu_cmplt,
  input  logic                    fpu_cmplt_dp,
  input  logic                    div_stall,
  input  logic                    bju_stall,
  input  logic                    bju_no_op,
  input  logic                    div_itering,
  output iu_ctrl_pkg::fwd_bus_t   idu_ex1_fwd,
  output logic                    ex2_rd_pair,
  output iu_ctrl_pkg::fwd_bus_t   wb0,
  output logic                    ex2_inst_vld,
  output logic                    lsu_grant,
  output logic                    div_grant,
  output logic                    div_vld,
  output iu_ctrl_pkg::rtu_ex1_t   rtu_ex1,
  output logic                    ex1_stall,
  output logic                    no_op
);

  import iu_ctrl_pkg::*;

  fwd_bus_t ex2_rslt;
  logic     ex2_idle;

  // EX1 forward select, the completion dp flags double as the select
  iu_ex1_fwd_mux u_fwd_mux (
    .cmplt_sel    (cmplt_sel),
    .dst_preg     (ex1_inst.dst_preg),
    .alu_rslt     (alu_rslt),
    .bju_rslt     (bju_rslt),
    .div_data     (div_data),
    .alu_fwd_vld  (alu_fwd_vld),
    .bju_rslt_vld (bju_rslt_vld),
    .div_fwd_vld  (div_fwd_vld),
    .ag_fwd       (ag_fwd),
    .ex1_fwd      (idu_ex1_fwd)
  );

  iu_ex1_ex2_pipe u_pipe (
    .iu_ex1_fwd_dp_clk (iu_ex1_fwd_dp_clk),
    .cpurst_b          (cpurst_b),
    .ex1_inst          (ex1_inst),
    .ex1_fwd           (idu_ex1_fwd),
    .bju_rslt_vld      (bju_rslt_vld),
    .spec_expt_pending (spec_expt_pending),
    .spec_halt_pending (spec_halt_pending),
    .warm_up           (warm_up),
    .flush             (flush),
    .ex2_rslt          (ex2_rslt),
    .ex2_rd_pair       (ex2_rd_pair)
  );

  iu_wb_arbiter u_wb_arb (
    .ex2_rslt     (ex2_rslt),
    .lsu_rslt     (lsu_rslt),
    .div_rslt     (div_rslt),
    .mul_inst_vld (mul_inst_vld),
    .mul_rslt_vld (mul_rslt_vld),
    .mul_rslt     (mul_rslt),
    .wb0          (wb0),
    .ex2_inst_vld (ex2_inst_vld),
    .div_grant    (div_grant),
    .lsu_grant    (lsu_grant),
    .div_vld      (div_vld),
    .ex2_idle     (ex2_idle)
  );

  iu_retire_ctrl u_retire (
    .ex1_inst          (ex1_inst),
    .alu_cmplt         (alu_cmplt),
    .alu_cmplt_dp      (cmplt_sel.alu),
    .mul_cmplt         (mul_cmplt),
    .mul_cmplt_dp      (cmplt_sel.mul),
    .div_cmplt         (div_cmplt),
    .div_cmplt_dp      (cmplt_sel.div),
    .fpu_cmplt         (fpu_cmplt),
    .fpu_cmplt_dp      (fpu_cmplt_dp),
    .spec_expt_pending (spec_expt_pending),
    .spec_halt_pending (spec_halt_pending),
    .div_stall         (div_stall),
    .bju_stall         (bju_stall),
    .bju_no_op         (bju_no_op),
    .div_itering       (div_itering),
    .ex2_idle          (ex2_idle),
    .rtu_ex1           (rtu_ex1),
    .ex1_stall         (ex1_stall),
    .no_op             (no_op)
  );

endmodule

//--- dv/iu_ctrl_tb.sv
// Self-checking testbench for the integer unit control block driven from the table of rows below
`include "iu_ctrl_macros.svh"

module iu_ctrl_tb;

  import iu_ctrl_pkg::*;

  localparam int NUM_ROWS = 32;

  // One cycle of DUT inputs
  typedef struct packed {
    cmplt_sel_t            cmplt_sel;
    ex1_inst_t             ex1_inst;
    logic [`IU_DATA_W-1:0] alu_rslt;
    logic                  alu_fwd_vld;
    logic [`IU_DATA_W-1:0] bju_rslt;
    logic                  bju_rslt_vld;
    logic [`IU_DATA_W-1:0] div_data;
    logic                  div_fwd_vld;
    fwd_bus_t              ag_fwd;
    logic                  spec_expt_pending;
    logic                  spec_halt_pending;
    logic                  warm_up;
    logic                  flush;
    fwd_bus_t              lsu_rslt;
    fwd_bus_t              div_rslt;
    logic                  mul_inst_vld;
    logic                  mul_rslt_vld;
    logic [`IU_DATA_W-1:0] mul_rslt;
    logic                  alu_cmplt;
    logic                  mul_cmplt;
    logic                  div_cmplt;
    logic                  fpu_cmplt;
    logic                  fpu_cmplt_dp;
    logic                  div_stall;
    logic                  bju_stall;
    logic                  bju_no_op;
    logic                  div_itering;
  } stim_t;

  // Expected outputs for the same cycle
  typedef struct packed {
    fwd_bus_t ex1_fwd;
    logic     ex2_rd_pair;
    fwd_bus_t wb0;
    logic     ex2_inst_vld;
    logic     lsu_grant;
    logic     div_grant;
    logic     div_vld;
    rtu_ex1_t rtu_ex1;
    logic     ex1_stall;
    logic     no_op;
  } exp_t;

  logic                  iu_ex1_fwd_dp_clk;
  logic                  cpurst_b;
  stim_t                 drv;
  fwd_bus_t              idu_ex1_fwd;
  fwd_bus_t              wb0;
  rtu_ex1_t              rtu_ex1;
  logic                  ex2_rd_pair;
  logic                  ex2_inst_vld;
  logic                  lsu_grant;
  logic                  div_grant;
  logic                  div_vld;
  logic                  ex1_stall;
  logic                  no_op;

  stim_t                 stim_tab [NUM_ROWS];
  exp_t                  exp_tab [NUM_ROWS];
  int                    n_rows;
  int                    cur_row;
  int                    n_checks;
  int                    n_errors;
  logic [15:0]           lfsr_state = 16'd25358;

  // Reference pipe state, advanced row by row
  logic                  m_vld;
  logic [`IU_PREG_W-1:0] m_preg;
  logic [`IU_DATA_W-1:0] m_data;
  logic                  m_pair;

  iu_ctrl_top dut (
    .iu_ex1_fwd_dp_clk (iu_ex1_fwd_dp_clk),
    .cpurst_b          (cpurst_b),
    .cmplt_sel         (drv.cmplt_sel),
    .ex1_inst          (drv.ex1_inst),
    .alu_rslt          (drv.alu_rslt),
    .alu_fwd_vld       (drv.alu_fwd_vld),
    .bju_rslt          (drv.bju_rslt),
    .bju_rslt_vld      (drv.bju_rslt_vld),
    .div_data          (drv.div_data),
    .div_fwd_vld       (drv.div_fwd_vld),
    .ag_fwd            (drv.ag_fwd),
    .spec_expt_pending (drv.spec_expt_pending),
    .spec_halt_pending (drv.spec_halt_pending),
    .warm_up           (drv.warm_up),
    .flush             (drv.flush),
    .lsu_rslt          (drv.lsu_rslt),
    .div_rslt          (drv.div_rslt),
    .mul_inst_vld      (drv.mul_inst_vld),
    .mul_rslt_vld      (drv.mul_rslt_vld),
    .mul_rslt          (drv.mul_rslt),
    .alu_cmplt         (drv.alu_cmplt),
    .mul_cmplt         (drv.mul_cmplt),
    .div_cmplt         (drv.div_cmplt),
    .fpu_cmplt         (drv.fpu_cmplt),
    .fpu_cmplt_dp      (drv.fpu_cmplt_dp),
    .div_stall         (drv.div_stall),
    .bju_stall         (drv.bju_stall),
    .bju_no_op         (drv.bju_no_op),
    .div_itering       (drv.div_itering),
    .idu_ex1_fwd       (idu_ex1_fwd),
    .ex2_rd_pair       (ex2_rd_pair),
    .wb0               (wb0),
    .ex2_inst_vld      (ex2_inst_vld),
    .lsu_grant         (lsu_grant),
    .div_grant         (div_grant),
    .div_vld           (div_vld),
    .rtu_ex1           (rtu_ex1),
    .ex1_stall         (ex1_stall),
    .no_op             (no_op)
  );

  // ====================
  // Random source
  // ====================

  // Galois LFSR stepped once per bit handed out
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit)
      lfsr_state = lfsr_state ^ 16'hB400;
    return out_bit;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v[i] = lfsr_step();
    return v;
  endfunction

  function automatic stim_t random_row();
    logic [$bits(stim_t)-1:0] raw;
    for (int i = 0; i < $bits(stim_t); i++)
      raw[i] = lfsr_step();
    return stim_t'(raw);
  endfunction

  // ====================
  // Row builders
  // ====================

  // Quiet cycle with fresh data words and tags
  function automatic stim_t idle_row();
    stim_t s;
    s = '0;
    s.ex1_inst.dst_preg = `IU_PREG_W'(rand_bits(`IU_PREG_W));
    s.alu_rslt = rand_bits(`IU_DATA_W);
    s.bju_rslt = rand_bits(`IU_DATA_W);
    s.div_data = rand_bits(`IU_DATA_W);
    s.mul_rslt = rand_bits(`IU_DATA_W);
    s.ag_fwd.preg = `IU_PREG_W'(rand_bits(`IU_PREG_W));
    s.ag_fwd.data = rand_bits(`IU_DATA_W);
    s.lsu_rslt.preg = `IU_PREG_W'(rand_bits(`IU_PREG_W));
    s.lsu_rslt.data = rand_bits(`IU_DATA_W);
    s.div_rslt.preg = `IU_PREG_W'(rand_bits(`IU_PREG_W));
    s.div_rslt.data = rand_bits(`IU_DATA_W);
    s.bju_no_op = 1'b1;
    return s;
  endfunction

  // ALU instruction in EX1 that writes back
  function automatic stim_t with_alu_wb(input stim_t s);
    s.cmplt_sel.alu = 1'b1;
    s.alu_fwd_vld = 1'b1;
    s.alu_cmplt = 1'b1;
    s.ex1_inst.inst_vld = 1'b1;
    s.ex1_inst.gateclk_vld = 1'b1;
    s.ex1_inst.alu_sel = 1'b1;
    s.ex1_inst.wb_vld = 1'b1;
    return s;
  endfunction

  // Works out the expected outputs of one row and stores the row
  task automatic add_row(input stim_t s);
    exp_t e;
    logic spec;
    logic rslt_vld;
    logic ex2_busy;
    e = '0;
    spec = s.spec_expt_pending | s.spec_halt_pending;
    // Only a single completion flag picks a source
    if ($countones(s.cmplt_sel) == 1)
    begin
      e.ex1_fwd.preg = s.ex1_inst.dst_preg;
      if (s.cmplt_sel.lsu)
        e.ex1_fwd = s.ag_fwd;
      else if (s.cmplt_sel.alu)
        e.ex1_fwd = {s.alu_fwd_vld, s.ex1_inst.dst_preg, s.alu_rslt};
      else if (s.cmplt_sel.bju)
        e.ex1_fwd = {s.bju_rslt_vld, s.ex1_inst.dst_preg, s.bju_rslt};
      else if (s.cmplt_sel.mul)
        e.ex1_fwd.data = s.alu_rslt;
      else
        e.ex1_fwd = {s.div_fwd_vld, s.ex1_inst.dst_preg, s.div_data};
    end
    rslt_vld = (s.bju_rslt_vld | (s.ex1_inst.inst_vld & s.ex1_inst.alu_sel &
               s.ex1_inst.wb_vld)) & ~spec;
    // Writeback port priority is pipe then MUL then LSU then DIV
    ex2_busy = m_vld | s.mul_inst_vld;
    e.ex2_inst_vld = ex2_busy;
    e.lsu_grant = s.lsu_rslt.vld & ~ex2_busy;
    e.div_grant = ~ex2_busy & ~s.lsu_rslt.vld;
    e.div_vld = s.div_rslt.vld & e.div_grant;
    e.ex2_rd_pair = m_pair;
    if (m_vld)
      e.wb0 = {1'b1, m_preg, m_data};
    else if (s.mul_rslt_vld)
      e.wb0 = {1'b1, m_preg, s.mul_rslt};
    else if (e.lsu_grant)
      e.wb0 = s.lsu_rslt;
    else if (e.div_vld)
      e.wb0 = s.div_rslt;
    // Retire side
    e.rtu_ex1.cmplt = s.alu_cmplt | s.mul_cmplt | s.div_cmplt | s.fpu_cmplt;
    e.rtu_ex1.cmplt_dp = s.cmplt_sel.alu | s.cmplt_sel.mul | s.cmplt_sel.div | s.fpu_cmplt_dp;
    e.rtu_ex1.inst_vld = s.ex1_inst.gateclk_vld;
    e.rtu_ex1.inst_len = s.ex1_inst.inst_len;
    e.rtu_ex1.split_inst = s.ex1_inst.split;
    e.rtu_ex1.ipop_int_mask = s.ex1_inst.ipop_int_mask & s.cmplt_sel.alu;
    e.rtu_ex1.ipush_mie_en = s.ex1_inst.ipush_mie_en & s.cmplt_sel.alu & ~spec;
    e.rtu_ex1.ipush_spec_fail = s.ex1_inst.ipush_spec_fail & s.cmplt_sel.alu;
    e.rtu_ex1.tail_int_vld = s.ex1_inst.tail_int_vld & s.cmplt_sel.alu;
    e.ex1_stall = s.div_stall | s.bju_stall;
    e.no_op = ~s.ex1_inst.inst_vld & ~e.wb0.vld & ~s.mul_inst_vld & s.bju_no_op &
              ~s.div_itering;
    // Pipe state after the next edge
    if (rslt_vld | s.warm_up)
      m_data = e.ex1_fwd.data;
    if (rslt_vld | s.warm_up |
        (s.ex1_inst.inst_vld & (s.ex1_inst.alu_sel | s.ex1_inst.mul_sel)))
    begin
      m_preg = e.ex1_fwd.preg;
      m_pair = s.ex1_inst.rd_pair;
    end
    m_vld = s.flush ? 1'b0 : rslt_vld;
    stim_tab[n_rows] = s;
    exp_tab[n_rows] = e;
    n_rows++;
  endtask

  task automatic build_table();
    stim_t s;
    // Reset cycles carry a BJU result with zero tag, data and pair bit
    m_vld = 1'b0;
    m_preg = '0;
    m_data = '0;
    m_pair = 1'b0;
    n_rows = 0;
    // Warm-up gives the EX2 registers known contents
    s = idle_row();
    s.warm_up = 1'b1;
    add_row(s);
    // Each completion flag in turn
    s = idle_row();
    s.cmplt_sel.lsu = 1'b1;
    s.ag_fwd.vld = 1'b1;
    add_row(s);
    s = with_alu_wb(idle_row());
    s.ex1_inst.ipop_int_mask = 1'b1;
    s.ex1_inst.tail_int_vld = 1'b1;
    s.ex1_inst.inst_len = 1'b1;
    s.ex1_inst.split = 1'b1;
    add_row(s);
    s = idle_row();
    s.cmplt_sel.bju = 1'b1;
    s.bju_rslt_vld = 1'b1;
    add_row(s);
    s = idle_row();
    s.cmplt_sel.mul = 1'b1;
    s.ex1_inst.inst_vld = 1'b1;
    s.ex1_inst.mul_sel = 1'b1;
    s.ex1_inst.rd_pair = 1'b1;
    add_row(s);
    s = idle_row();
    s.cmplt_sel.div = 1'b1;
    s.div_fwd_vld = 1'b1;
    s.mul_inst_vld = 1'b1;
    s.mul_rslt_vld = 1'b1;
    add_row(s);
    // No flag and then two flags
    s = idle_row();
    s.alu_fwd_vld = 1'b1;
    s.div_fwd_vld = 1'b1;
    s.ag_fwd.vld = 1'b1;
    add_row(s);
    s = idle_row();
    s.cmplt_sel.alu = 1'b1;
    s.cmplt_sel.bju = 1'b1;
    s.alu_fwd_vld = 1'b1;
    s.bju_rslt_vld = 1'b1;
    add_row(s);
    // Pending speculation, flush and a waiting LSU or DIV result
    s = with_alu_wb(idle_row());
    s.ex1_inst.ipush_mie_en = 1'b1;
    s.spec_expt_pending = 1'b1;
    s.lsu_rslt.vld = 1'b1;
    add_row(s);
    s = with_alu_wb(idle_row());
    s.spec_halt_pending = 1'b1;
    s.lsu_rslt.vld = 1'b1;
    s.div_rslt.vld = 1'b1;
    add_row(s);
    s = with_alu_wb(idle_row());
    s.flush = 1'b1;
    s.div_rslt.vld = 1'b1;
    add_row(s);
    add_row(idle_row());
    s = with_alu_wb(idle_row());
    s.ex1_inst.ipush_mie_en = 1'b1;
    s.ex1_inst.ipush_spec_fail = 1'b1;
    s.ex1_inst.ipop_int_mask = 1'b1;
    s.ex1_inst.tail_int_vld = 1'b1;
    add_row(s);
    s = idle_row();
    s.lsu_rslt.vld = 1'b1;
    s.div_rslt.vld = 1'b1;
    add_row(s);
    s = idle_row();
    s.mul_inst_vld = 1'b1;
    s.lsu_rslt.vld = 1'b1;
    add_row(s);
    // Completion ORs, stalls and idle
    s = idle_row();
    s.mul_cmplt = 1'b1;
    s.div_cmplt = 1'b1;
    s.fpu_cmplt_dp = 1'b1;
    s.div_stall = 1'b1;
    add_row(s);
    s = idle_row();
    s.bju_stall = 1'b1;
    add_row(s);
    s = idle_row();
    s.div_itering = 1'b1;
    add_row(s);
    s = idle_row();
    s.ex1_inst.inst_vld = 1'b1;
    add_row(s);
    while (n_rows < NUM_ROWS)
      add_row(random_row());
  endtask

  // ====================
  // Checking
  // ====================

  task automatic compare(input logic [63:0] got, input logic [63:0] want, input string what);
    n_checks++;
    if (got !== want)
    begin
      n_errors++;
      $display("Error at %0t: row %0d %s is %h, expected %h", $time, cur_row, what, got, want);
    end
  endtask

  task automatic check_row(input int r);
    exp_t e;
    e = exp_tab[r];
    cur_row = r;
    compare(64'(idu_ex1_fwd), 64'(e.ex1_fwd), "EX1 forward bus");
    compare(64'(ex2_rd_pair), 64'(e.ex2_rd_pair), "EX2 rd_pair");
    compare(64'(wb0), 64'(e.wb0), "wb0");
    compare(64'(ex2_inst_vld), 64'(e.ex2_inst_vld), "EX2 inst_vld");
    compare(64'(lsu_grant), 64'(e.lsu_grant), "LSU grant");
    compare(64'(div_grant), 64'(e.div_grant), "DIV grant");
    compare(64'(div_vld), 64'(e.div_vld), "div_vld");
    compare(64'(rtu_ex1), 64'(e.rtu_ex1), "retire EX1 bundle");
    compare(64'(ex1_stall), 64'(e.ex1_stall), "EX1 stall");
    compare(64'(no_op), 64'(e.no_op), "no_op");
  endtask

  initial
  begin
    iu_ex1_fwd_dp_clk = 1'b0;
    forever
      #4 iu_ex1_fwd_dp_clk = ~iu_ex1_fwd_dp_clk;
  end

  initial
  begin
    #((NUM_ROWS + 10) * 8);
    $display("Watchdog timeout: the table did not finish in the expected time");
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    cpurst_b = 1'b0;
    drv = '0;
    // A BJU result held through reset must leave the pipe valid clear
    drv.bju_rslt_vld = 1'b1;
    n_checks = 0;
    n_errors = 0;
    build_table();
    repeat (3) @(posedge iu_ex1_fwd_dp_clk);
    #1;
    cpurst_b = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      drv = stim_tab[r];
      @(negedge iu_ex1_fwd_dp_clk);
      check_row(r);
      @(posedge iu_ex1_fwd_dp_clk);
      #1;
    end
    $display("Checks run %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
source/iu_ctrl_pkg.sv
source/iu_ex1_fwd_mux.sv
source/iu_ex1_ex2_pipe.sv
source/iu_wb_arbiter.sv
source/iu_retire_ctrl.sv
source/iu_ctrl_top.sv
dv/iu_ctrl_tb.sv

//--- Makefile
TOP := iu_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
